//--- hw/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// Datapath word and register number
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	// Cycle count for Tuse and Tnew
	typedef logic [2:0] stageTime_t;

	// One bit per supported instruction
	typedef logic [8:0] instrKind_t;

	// Bit positions in instrKind_t
	localparam int KIND_ADDU = 0;
	localparam int KIND_SUBU = 1;
	localparam int KIND_ORI = 2;
	localparam int KIND_LUI = 3;
	localparam int KIND_SLL = 4;
	localparam int KIND_LW = 5;
	localparam int KIND_LBU = 6;
	localparam int KIND_SW = 7;
	localparam int KIND_SB = 8;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_LBU = 6'h24;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] OP_SB = 6'h28;

	// Funct codes under OP_SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_SLL = 6'h00;

	// Operand needed in decode
	localparam stageTime_t TUSE_NOW = 3'd0;
	// Store data, needed one stage later
	localparam stageTime_t TUSE_STORE = 3'd1;
	// Operand not read at all
	localparam stageTime_t TUSE_NONE = 3'd7;

	// Result ready after execute or after the memory read
	localparam stageTime_t TNEW_ALU = 3'd1;
	localparam stageTime_t TNEW_LOAD = 3'd2;

endpackage

`default_nettype wire

//--- hw/cpuMemPkg.sv
`default_nettype none

package cpuMemPkg;

	// Lane enables for the four bytes of a word
	typedef logic [3:0] byteEn_t;

	// Data memory size in words
	localparam int DM_WORDS = 1024;

	// Word index into data memory
	typedef logic [9:0] dmIndex_t;

	// PC value seen in every stage after reset
	localparam logic [31:0] RESET_PC = 32'h0000_3000;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
	import cpuIsaPkg::*;
(
	input wire clk,
	input wire reset,
	input wire regAddr_t rAddr0,
	input wire regAddr_t rAddr1,
	output word_t rData0,
	output word_t rData1,
	input wire wEn,
	input wire regAddr_t wAddr,
	input wire word_t wData
);

	// r1 to r31, r0 has no storage
	word_t regs [1:31];

	// Zero register, then same-cycle write, then stored value
	function automatic word_t readPort(regAddr_t addr);
		if (addr == '0)
			return '0;
		if (wEn && wAddr == addr)
			return wData;
		return regs[addr];
	endfunction

	always_comb
	begin
		rData0 = readPort(rAddr0);
		rData1 = readPort(rAddr1);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wEn && wAddr != '0)
			regs[wAddr] <= wData;
	end

endmodule

`default_nettype wire

//--- hw/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode
	import cpuIsaPkg::*;
	import cpuMemPkg::*;
(
	input wire clk,
	input wire reset,
	input wire word_t instrIn,
	input wire word_t pcIn,
	output regAddr_t rAddr0,
	output regAddr_t rAddr1,
	input wire word_t rData0,
	input wire word_t rData1,
	input wire regAddr_t memDest,
	input wire stageTime_t memTnew,
	input wire word_t memAluOut,
	input wire commitEn,
	input wire regAddr_t commitAddr,
	input wire word_t commitData,
	output logic hold,
	output logic exValid,
	output instrKind_t exKind,
	output word_t exA,
	output word_t exB,
	output word_t exImm,
	output logic [4:0] exShamt,
	output regAddr_t exDest,
	output stageTime_t exTnew,
	output logic exStoreFromWb,
	output word_t exPc
);

	// Instruction fields
	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	logic [4:0] shamt;
	logic [15:0] imm16;

	assign opcode = instrIn[31:26];
	assign rs = instrIn[25:21];
	assign rt = instrIn[20:16];
	assign rd = instrIn[15:11];
	assign shamt = instrIn[10:6];
	assign funct = instrIn[5:0];
	assign imm16 = instrIn[15:0];

	// Register file read straight from the fields
	assign rAddr0 = rs;
	assign rAddr1 = rt;

	////////////////////////////////////////////////////////////
	// Kind decode
	instrKind_t kind;

	always_comb
	begin
		kind = '0;
		case (opcode)
			OP_SPECIAL:
			begin
				case (funct)
					FN_ADDU: kind[KIND_ADDU] = 1'b1;
					FN_SUBU: kind[KIND_SUBU] = 1'b1;
					FN_SLL: kind[KIND_SLL] = 1'b1;
					default: kind = '0;
				endcase
			end
			OP_ORI: kind[KIND_ORI] = 1'b1;
			OP_LUI: kind[KIND_LUI] = 1'b1;
			OP_LW: kind[KIND_LW] = 1'b1;
			OP_LBU: kind[KIND_LBU] = 1'b1;
			OP_SW: kind[KIND_SW] = 1'b1;
			OP_SB: kind[KIND_SB] = 1'b1;
			// Unknown opcode leaves kind empty
			default: kind = '0;
		endcase
	end

	logic isAlu;
	logic isLoad;
	logic isStore;
	logic rdForm;

	assign rdForm = kind[KIND_ADDU] | kind[KIND_SUBU] | kind[KIND_SLL];
	assign isAlu = rdForm | kind[KIND_ORI] | kind[KIND_LUI];
	assign isLoad = kind[KIND_LW] | kind[KIND_LBU];
	assign isStore = kind[KIND_SW] | kind[KIND_SB];

	// Tuse per source, Tnew and destination
	stageTime_t tuseRs;
	stageTime_t tuseRt;
	stageTime_t tnew;
	regAddr_t dest;

	// rs is read by everything except lui and sll
	assign tuseRs = (kind == '0 || kind[KIND_LUI] || kind[KIND_SLL]) ? TUSE_NONE : TUSE_NOW;
	assign tuseRt = rdForm ? TUSE_NOW : (isStore ? TUSE_STORE : TUSE_NONE);
	assign dest = rdForm ? rd : ((isAlu || isLoad) ? rt : '0);
	assign tnew = isLoad ? TNEW_LOAD : (isAlu ? TNEW_ALU : '0);

	////////////////////////////////////////////////////////////
	// Hazard detection
	// An EX/MEM producer is usable only once finished, since the
	// WB bypass in memAccess only reaches the instruction just ahead
	function automatic logic lateOperand(regAddr_t src, stageTime_t tuse);
		logic exLate;
		logic memLate;
		exLate = (src != '0) && (src == exDest) && (exTnew > tuse);
		memLate = (src != '0) && (src == memDest) && (memTnew != '0) && (tuse != TUSE_NONE);
		return exLate || memLate;
	endfunction

	always_comb
		hold = lateOperand(rs, tuseRs) | lateOperand(rt, tuseRt);

	// Store data from the ALU op just ahead arrives on the commit port later
	logic storeFromWb;
	assign storeFromWb = isStore && (rt != '0) && (rt == exDest);

	// Youngest finished producer wins
	function automatic word_t fwdOperand(regAddr_t src, word_t rfData);
		word_t val;
		val = rfData;
		if (commitEn && commitAddr == src)
			val = commitData;
		if (src != '0 && memDest == src && memTnew == '0)
			val = memAluOut;
		return val;
	endfunction

	////////////////////////////////////////////////////////////
	// ID/EX register
	logic accept;
	assign accept = !hold && (kind != '0);

	// Control part, bubble when holding or undecodable
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exValid <= 1'b0;
			exKind <= '0;
			exDest <= '0;
			exTnew <= '0;
			exStoreFromWb <= 1'b0;
			exPc <= RESET_PC;
		end
		else
		begin
			exValid <= accept;
			exKind <= accept ? kind : '0;
			exDest <= accept ? dest : '0;
			exTnew <= accept ? tnew : '0;
			exStoreFromWb <= accept && storeFromWb;
			exPc <= pcIn;
		end
	end

	// Operands and immediates
	always_ff @(posedge clk)
	begin
		exA <= fwdOperand(rs, rData0);
		exB <= fwdOperand(rt, rData1);
		// Offsets sign-extended, ori and lui zero-extended
		exImm <= (isLoad || isStore) ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
		exShamt <= shamt;
	end

	// A stall always points at an instruction further down
	assert property (@(posedge clk) disable iff (reset)
		(!exValid && memDest == '0) |-> !hold);

endmodule

`default_nettype wire

//--- hw/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute
	import cpuIsaPkg::*;
	import cpuMemPkg::*;
(
	input wire clk,
	input wire reset,
	input wire exValid,
	input wire instrKind_t exKind,
	input wire word_t exA,
	input wire word_t exB,
	input wire word_t exImm,
	input wire [4:0] exShamt,
	input wire regAddr_t exDest,
	input wire stageTime_t exTnew,
	input wire exStoreFromWb,
	input wire word_t exPc,
	output logic memValid,
	output instrKind_t memKind,
	output word_t memAluOut,
	output word_t memStoreData,
	output regAddr_t memDest,
	output stageTime_t memTnew,
	output logic memStoreFromWb,
	output word_t memPc
);

	// ALU
	word_t aluOut;

	always_comb
	begin
		// Address add for loads and stores
		aluOut = exA + exImm;
		if (exKind[KIND_ADDU])
			aluOut = exA + exB;
		else if (exKind[KIND_SUBU])
			aluOut = exA - exB;
		else if (exKind[KIND_ORI])
			aluOut = exA | exImm;
		else if (exKind[KIND_LUI])
			aluOut = {exImm[15:0], 16'h0000};
		else if (exKind[KIND_SLL])
			aluOut = exB << exShamt;
	end

	// One stage closer to a ready result
	stageTime_t tnewNext;
	assign tnewNext = (exTnew != '0) ? exTnew - 3'd1 : '0;

	// EX/MEM control
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			memValid <= 1'b0;
			memKind <= '0;
			memDest <= '0;
			memTnew <= '0;
			memStoreFromWb <= 1'b0;
			memPc <= RESET_PC;
		end
		else
		begin
			memValid <= exValid;
			memKind <= exKind;
			memDest <= exDest;
			memTnew <= tnewNext;
			memStoreFromWb <= exStoreFromWb;
			memPc <= exPc;
		end
	end

	// EX/MEM data
	always_ff @(posedge clk)
	begin
		memAluOut <= aluOut;
		memStoreData <= exB;
	end

	// Decode hands over exactly one kind per valid slot
	assert property (@(posedge clk) disable iff (reset)
		exValid |-> $onehot(exKind));

endmodule

`default_nettype wire

//--- hw/memAccess.sv
`timescale 1ns/1ps
`default_nettype none

module memAccess
	import cpuIsaPkg::*;
	import cpuMemPkg::*;
(
	input wire clk,
	input wire reset,
	input wire memValid,
	input wire instrKind_t memKind,
	input wire word_t memAluOut,
	input wire word_t memStoreData,
	input wire regAddr_t memDest,
	input wire stageTime_t memTnew,
	input wire memStoreFromWb,
	input wire word_t memPc,
	output logic commitEn,
	output regAddr_t commitAddr,
	output word_t commitData,
	output word_t commitPc
);

	// Word index and byte lane from the address
	dmIndex_t dmIndex;
	logic [1:0] byteSel;

	assign dmIndex = memAluOut[11:2];
	assign byteSel = memAluOut[1:0];

	logic isLoad;
	assign isLoad = memKind[KIND_LW] | memKind[KIND_LBU];

	////////////////////////////////////////////////////////////
	// Store path
	word_t storeData;
	word_t storeWord;
	byteEn_t byteEn;

	// Value from the instruction now committing
	assign storeData = memStoreFromWb ? commitData : memStoreData;

	// sb copies its byte to every lane
	assign storeWord = memKind[KIND_SB] ? {4{storeData[7:0]}} : storeData;

	always_comb
	begin
		byteEn = '0;
		if (memValid && memKind[KIND_SW])
			byteEn = 4'b1111;
		else if (memValid && memKind[KIND_SB])
			byteEn = byteEn_t'(4'b0001 << byteSel);
	end

	////////////////////////////////////////////////////////////
	// Data memory
	word_t dataMem [DM_WORDS];

	always_ff @(posedge clk)
	begin
		for (int lane = 0; lane < 4; lane++)
		begin
			if (byteEn[lane])
				dataMem[dmIndex][lane*8 +: 8] <= storeWord[lane*8 +: 8];
		end
	end

	// Load path
	word_t readWord;
	logic [7:0] readByte;
	word_t result;

	assign readWord = dataMem[dmIndex];
	assign readByte = readWord[{byteSel, 3'b000} +: 8];

	always_comb
	begin
		result = memAluOut;
		if (memKind[KIND_LW])
			result = readWord;
		else if (memKind[KIND_LBU])
			result = {24'h000000, readByte};
	end

	////////////////////////////////////////////////////////////
	// MEM/WB register and commit port
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			commitEn <= 1'b0;
			commitAddr <= '0;
			commitPc <= RESET_PC;
		end
		else
		begin
			// Stores and bubbles carry no destination
			commitEn <= memValid && (memDest != '0);
			commitAddr <= memDest;
			commitPc <= memPc;
		end
	end

	always_ff @(posedge clk)
		commitData <= result;

	// Word accesses stay aligned
	assert property (@(posedge clk) disable iff (reset)
		memValid && (memKind[KIND_SW] || memKind[KIND_LW]) |-> memAluOut[1:0] == 2'b00);

	// Countdown from decode through execute lands here one step from done for loads
	assert property (@(posedge clk) disable iff (reset)
		memValid && (memDest != '0) |-> memTnew == stageTime_t'(isLoad));

endmodule

`default_nettype wire

//--- hw/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore
	import cpuIsaPkg::*;
(
	input wire clk,
	input wire reset,
	input wire word_t instrIn,
	input wire word_t pcIn,
	output logic hold,
	output logic commitEn,
	output regAddr_t commitAddr,
	output word_t commitData,
	output word_t commitPc
);

	// Register file reads
	regAddr_t rAddr0;
	regAddr_t rAddr1;
	word_t rData0;
	word_t rData1;

	// ID/EX
	logic exValid;
	instrKind_t exKind;
	word_t exA;
	word_t exB;
	word_t exImm;
	logic [4:0] exShamt;
	regAddr_t exDest;
	stageTime_t exTnew;
	logic exStoreFromWb;
	word_t exPc;

	// EX/MEM
	logic memValid;
	instrKind_t memKind;
	word_t memAluOut;
	word_t memStoreData;
	regAddr_t memDest;
	stageTime_t memTnew;
	logic memStoreFromWb;
	word_t memPc;

	// Written back from the commit port
	regFile regs (
		.clk(clk), .reset(reset),
		.rAddr0(rAddr0), .rAddr1(rAddr1), .rData0(rData0), .rData1(rData1),
		.wEn(commitEn), .wAddr(commitAddr), .wData(commitData)
	);

	instrDecode decode (
		.clk(clk), .reset(reset), .instrIn(instrIn), .pcIn(pcIn),
		.rAddr0(rAddr0), .rAddr1(rAddr1), .rData0(rData0), .rData1(rData1),
		.memDest(memDest), .memTnew(memTnew), .memAluOut(memAluOut),
		.commitEn(commitEn), .commitAddr(commitAddr), .commitData(commitData),
		.hold(hold), .exValid(exValid), .exKind(exKind), .exA(exA), .exB(exB),
		.exImm(exImm), .exShamt(exShamt), .exDest(exDest), .exTnew(exTnew),
		.exStoreFromWb(exStoreFromWb), .exPc(exPc)
	);

	aluExecute execute (
		.clk(clk), .reset(reset), .exValid(exValid), .exKind(exKind),
		.exA(exA), .exB(exB), .exImm(exImm), .exShamt(exShamt), .exDest(exDest),
		.exTnew(exTnew), .exStoreFromWb(exStoreFromWb), .exPc(exPc),
		.memValid(memValid), .memKind(memKind), .memAluOut(memAluOut),
		.memStoreData(memStoreData), .memDest(memDest), .memTnew(memTnew),
		.memStoreFromWb(memStoreFromWb), .memPc(memPc)
	);

	memAccess memory (
		.clk(clk), .reset(reset), .memValid(memValid), .memKind(memKind),
		.memAluOut(memAluOut), .memStoreData(memStoreData), .memDest(memDest),
		.memTnew(memTnew), .memStoreFromWb(memStoreFromWb), .memPc(memPc),
		.commitEn(commitEn), .commitAddr(commitAddr), .commitData(commitData),
		.commitPc(commitPc)
	);

endmodule

`default_nettype wire

//--- dv/cpuRefModel.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state, first 64 bytes of memory only
word_t modelReg [0:31];
logic [7:0] modelMem [0:63];

// Expected commits in program order
regAddr_t expAddr [$];
word_t expData [$];
word_t expPc [$];

// One instruction against the model, in program order
function automatic void refExecute(input word_t instr, input word_t pc);
	logic [5:0] op;
	logic [5:0] fn;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t addr;
	word_t result;
	regAddr_t dest;
	op = instr[31:26];
	fn = instr[5:0];
	rs = instr[25:21];
	rt = instr[20:16];
	rd = instr[15:11];
	// Effective address, offset sign-extended
	addr = modelReg[rs] + {{16{instr[15]}}, instr[15:0]};
	result = '0;
	dest = '0;
	case (op)
		OP_SPECIAL:
		begin
			dest = rd;
			if (fn == FN_ADDU)
				result = modelReg[rs] + modelReg[rt];
			else if (fn == FN_SUBU)
				result = modelReg[rs] - modelReg[rt];
			else if (fn == FN_SLL)
				result = modelReg[rt] << instr[10:6];
			else
				dest = '0;
		end
		OP_ORI:
		begin
			dest = rt;
			result = modelReg[rs] | {16'h0000, instr[15:0]};
		end
		OP_LUI:
		begin
			dest = rt;
			result = {instr[15:0], 16'h0000};
		end
		// Little-endian lanes, byte 0 at bits 7:0
		OP_LW:
		begin
			dest = rt;
			result = {modelMem[{addr[5:2], 2'd3}], modelMem[{addr[5:2], 2'd2}],
				modelMem[{addr[5:2], 2'd1}], modelMem[{addr[5:2], 2'd0}]};
		end
		OP_LBU:
		begin
			dest = rt;
			result = {24'h000000, modelMem[addr[5:0]]};
		end
		OP_SW:
		begin
			for (int b = 0; b < 4; b++)
				modelMem[{addr[5:2], 2'(b)}] = modelReg[rt][8*b +: 8];
		end
		OP_SB: modelMem[addr[5:0]] = modelReg[rt][7:0];
		default: dest = '0;
	endcase
	// r0 never changes and never commits
	if (dest != '0)
	begin
		modelReg[dest] = result;
		expAddr.push_back(dest);
		expData.push_back(result);
		expPc.push_back(pc);
	end
endfunction

`endif

//--- dv/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb
	import cpuIsaPkg::*;
	import cpuMemPkg::*;
;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_COUNT = 200;

	logic clk;
	logic reset;
	word_t instrIn;
	word_t pcIn;
	logic hold;
	logic commitEn;
	regAddr_t commitAddr;
	word_t commitData;
	word_t commitPc;

	int valueErrors = 0;
	int flowErrors = 0;
	int commitCount = 0;
	int cycleCount;
	int cycleLimit;

	word_t prog [$];
	logic [31:0] lfsrState;

	`include "cpuRefModel.svh"

	cpuCore dut (
		.clk(clk), .reset(reset), .instrIn(instrIn), .pcIn(pcIn), .hold(hold),
		.commitEn(commitEn), .commitAddr(commitAddr), .commitData(commitData),
		.commitPc(commitPc)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
		end
		return val;
	endfunction

	// r1 to r7 only, so hazards come often
	function automatic regAddr_t randReg();
		return regAddr_t'(1 + takeBits(3) % 7);
	endfunction

	function automatic word_t rType(input logic [5:0] fn, input regAddr_t rs,
		input regAddr_t rt, input regAddr_t rd, input logic [4:0] sh);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t iType(input logic [5:0] op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic checkValue(input string what, input word_t got, input word_t expected);
		if (got !== expected)
		begin
			valueErrors++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic endRun();
		$display("Errors: %0d value mismatches, %0d flow errors, %0d commits checked",
			valueErrors, flowErrors, commitCount);
		if (valueErrors == 0 && flowErrors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Program: clear memory, directed cases, random tail
	task automatic buildProgram();
		int sel;
		lfsrState = 32'h69ce7046;
		// Zero the 16 words the program touches
		for (int i = 0; i < 16; i++)
			prog.push_back(iType(OP_SW, 5'd0, 5'd0, 16'(i * 4)));
		// Independent ALU ops
		prog.push_back(iType(OP_ORI, 5'd0, 5'd1, 16'h1234));
		prog.push_back(iType(OP_LUI, 5'd0, 5'd2, 16'habcd));
		prog.push_back(iType(OP_ORI, 5'd0, 5'd3, 16'h0f0f));
		prog.push_back(rType(FN_SLL, 5'd0, 5'd1, 5'd4, 5'd8));
		// Dependency chain through EX/MEM and WB
		prog.push_back(rType(FN_ADDU, 5'd1, 5'd2, 5'd5, 5'd0));
		prog.push_back(rType(FN_SUBU, 5'd5, 5'd3, 5'd6, 5'd0));
		prog.push_back(rType(FN_ADDU, 5'd6, 5'd6, 5'd7, 5'd0));
		// Store data from the ALU op just ahead
		prog.push_back(iType(OP_SW, 5'd0, 5'd7, 16'h0020));
		// Load then consumer
		prog.push_back(iType(OP_LW, 5'd0, 5'd1, 16'h0020));
		prog.push_back(rType(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
		// One sb per lane
		prog.push_back(iType(OP_SB, 5'd0, 5'd2, 16'h0030));
		prog.push_back(iType(OP_SB, 5'd0, 5'd5, 16'h0031));
		prog.push_back(iType(OP_SB, 5'd0, 5'd6, 16'h0032));
		prog.push_back(iType(OP_SB, 5'd0, 5'd7, 16'h0033));
		prog.push_back(iType(OP_LW, 5'd0, 5'd3, 16'h0030));
		prog.push_back(iType(OP_LBU, 5'd0, 5'd4, 16'h0031));
		prog.push_back(iType(OP_LBU, 5'd0, 5'd5, 16'h0033));
		// Store data from the load just ahead
		prog.push_back(iType(OP_LW, 5'd0, 5'd6, 16'h0020));
		prog.push_back(iType(OP_SW, 5'd0, 5'd6, 16'h0024));
		prog.push_back(iType(OP_LBU, 5'd0, 5'd7, 16'h0026));
		prog.push_back(iType(OP_LW, 5'd0, 5'd1, 16'h0024));
		// Random mix, memory based on r0 within 64 bytes
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			sel = int'(takeBits(4) % 9);
			case (sel)
				0: prog.push_back(rType(FN_ADDU, randReg(), randReg(), randReg(), 5'd0));
				1: prog.push_back(rType(FN_SUBU, randReg(), randReg(), randReg(), 5'd0));
				2: prog.push_back(iType(OP_ORI, randReg(), randReg(), 16'(takeBits(16))));
				3: prog.push_back(iType(OP_LUI, 5'd0, randReg(), 16'(takeBits(16))));
				4: prog.push_back(rType(FN_SLL, 5'd0, randReg(), randReg(), 5'(takeBits(5))));
				5: prog.push_back(iType(OP_LW, 5'd0, randReg(), 16'(takeBits(4) << 2)));
				6: prog.push_back(iType(OP_LBU, 5'd0, randReg(), 16'(takeBits(6))));
				7: prog.push_back(iType(OP_SW, 5'd0, randReg(), 16'(takeBits(4) << 2)));
				default: prog.push_back(iType(OP_SB, 5'd0, randReg(), 16'(takeBits(6))));
			endcase
		end
		cycleLimit = 4 * prog.size() + 100;
	endtask

	////////////////////////////////////////////////////////////
	// Driver
	initial
	begin
		int idx;
		reset = 1'b1;
		instrIn = '0;
		pcIn = RESET_PC;
		for (int r = 0; r < 32; r++)
			modelReg[r] = '0;
		for (int b = 0; b < 64; b++)
			modelMem[b] = '0;
		buildProgram();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// Idle nops, nothing may commit or stall
		repeat (4)
		begin
			@(posedge clk);
			checkValue("hold while idle", 32'(hold), 32'd0);
			checkValue("commitEn while idle", 32'(commitEn), 32'd0);
		end
		idx = 0;
		instrIn <= prog[0];
		pcIn <= RESET_PC;
		while (idx < prog.size())
		begin
			@(posedge clk);
			// Accepted on this edge
			if (!hold)
			begin
				refExecute(prog[idx], RESET_PC + (word_t'(idx) << 2));
				idx++;
				instrIn <= (idx < prog.size()) ? prog[idx] : '0;
				pcIn <= RESET_PC + (word_t'(idx) << 2);
			end
		end
		// Drain, then a few cycles to catch stray commits
		while (expData.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		endRun();
	end

	////////////////////////////////////////////////////////////
	// Commit checker
	always @(posedge clk)
	begin : commitCheck
		word_t pcExp;
		if (!reset && commitEn)
		begin
			if (expData.size() == 0)
			begin
				flowErrors++;
				$display("Commit at %0t ns to r%0d with no instruction outstanding",
					$time, commitAddr);
			end
			else
			begin
				pcExp = expPc.pop_front();
				commitCount++;
				checkValue("commit pc", commitPc, pcExp);
				checkValue($sformatf("dest of pc %h", pcExp), 32'(commitAddr),
					32'(expAddr.pop_front()));
				checkValue($sformatf("data of pc %h", pcExp), commitData, expData.pop_front());
			end
		end
	end

	// Watchdog
	initial
	begin
		cycleCount = 0;
		do
		begin
			@(posedge clk);
			cycleCount++;
		end
		while (cycleCount < cycleLimit);
		flowErrors++;
		$display("Timeout after %0d cycles with %0d commits still expected",
			cycleCount, expData.size());
		endRun();
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+dv
hw/cpuIsaPkg.sv
hw/cpuMemPkg.sv
hw/regFile.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/memAccess.sv
hw/cpuCore.sv
dv/cpuCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
	--top-module cpuCoreTb \
	-f list.f \
	-o simCpuCore

./obj_dir/simCpuCore 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation finished, see sim.log"
